// File: vector_table.svh
`ifndef VECTOR_TABLE_SVH
`define VECTOR_TABLE_SVH

// Loopback step. madr[5:0] feeds p10..p15, the LCD pins feed the address inputs.
function automatic board_bus_pkg::test_vector_t loop_row(
	input logic [board_bus_pkg::pxx_w-1:0] addr,
	input board_bus_pkg::lcd_pins_t        lcd,
	input logic                            pxx_test,
	input logic                            lcd_test,
	input logic [board_bus_pkg::lcd_w-1:0] exp_adr
);
	board_bus_pkg::test_vector_t v;
	v = '0;
	v.mem.addr[board_bus_pkg::pxx_w-1:0] = addr;
	v.lcd = lcd;
	v.pxx_test = pxx_test;
	v.lcd_test = lcd_test;
	v.exp_adr = exp_adr;
	return v;
endfunction

// Memory step, either the cartridge ROM alone or XRAM and VRAM together.
function automatic board_bus_pkg::test_vector_t mem_row(
	input logic                                 rom,
	input logic                                 wr,
	input logic                                 rd,
	input logic                                 test,
	input logic [board_bus_pkg::mem_addr_w-1:0] maddr,
	input logic [board_bus_pkg::data_w-1:0]     mdata,
	input logic [board_bus_pkg::vid_addr_w-1:0] vaddr,
	input logic [board_bus_pkg::data_w-1:0]     vdata
);
	board_bus_pkg::test_vector_t v;
	v = '0;
	v.mem.addr = maddr;
	v.mem.data = mdata;
	v.mem.oe = wr;
	v.mem.rd = rd;
	v.mem.prog = rom & wr;
	v.mem.wr = !rom & wr;
	v.mem.cs_rom = rom;
	v.mem.cs_xram = !rom;
	v.vid.addr = vaddr;
	v.vid.data = vdata;
	v.vid.oe = !rom & wr;
	v.vid.rd = !rom & rd;
	v.vid.wr = !rom & wr;
	v.vid.cs = !rom;
	v.md_test = test;
	v.vd_test = !rom & test;
	return v;
endfunction

// A check tests what the previous step drove.
function automatic board_bus_pkg::test_vector_t vector_row(input int unsigned idx);
	board_bus_pkg::test_vector_t v;
	case (idx)
		0:  v = loop_row(6'h15, 8'haa, 1'b0, 1'b0, 8'h00);
		1:  v = loop_row(6'h15, 8'h55, 1'b1, 1'b1, 8'hd4);
		2:  v = loop_row(6'h2a, 8'h54, 1'b0, 1'b1, 8'h2b);
		3:  v = loop_row(6'h2a, 8'h51, 1'b1, 1'b1, 8'h0b);
		4:  v = loop_row(6'h03, 8'h00, 1'b0, 1'b1, 8'h23);
		5:  v = loop_row(6'h03, 8'h00, 1'b1, 1'b0, 8'h00);
		6:  v = loop_row(6'h3c, 8'h00, 1'b0, 1'b0, 8'h00);
		7:  v = loop_row(6'h3c, 8'h00, 1'b1, 1'b0, 8'h00);
		// Program the ROM.
		8:  v = mem_row(1'b1, 1'b1, 1'b0, 1'b0, 21'h000000, 8'h55, 14'h0000, 8'h00);
		9:  v = mem_row(1'b1, 1'b1, 1'b0, 1'b0, 21'h000001, 8'haa, 14'h0000, 8'h00);
		10: v = mem_row(1'b1, 1'b1, 1'b0, 1'b0, 21'h000100, 8'h33, 14'h0000, 8'h00);
		11: v = mem_row(1'b1, 1'b1, 1'b0, 1'b0, 21'h100000, 8'hcc, 14'h0000, 8'h00);
		// Fill XRAM and VRAM.
		12: v = mem_row(1'b0, 1'b1, 1'b0, 1'b0, 21'h000000, 8'h40, 14'h0000, 8'h55);
		13: v = mem_row(1'b0, 1'b1, 1'b0, 1'b0, 21'h000002, 8'h41, 14'h0001, 8'haa);
		14: v = mem_row(1'b0, 1'b1, 1'b0, 1'b0, 21'h000400, 8'h42, 14'h0040, 8'h0f);
		15: v = mem_row(1'b0, 1'b1, 1'b0, 1'b0, 21'h010000, 8'h43, 14'h2000, 8'hf0);
		// Read back the ROM.
		16: v = mem_row(1'b1, 1'b0, 1'b1, 1'b0, 21'h000000, 8'h00, 14'h0000, 8'h00);
		17: v = mem_row(1'b1, 1'b0, 1'b1, 1'b1, 21'h000001, 8'h55, 14'h0000, 8'h00);
		18: v = mem_row(1'b1, 1'b0, 1'b1, 1'b1, 21'h000100, 8'haa, 14'h0000, 8'h00);
		19: v = mem_row(1'b1, 1'b0, 1'b1, 1'b1, 21'h100000, 8'h33, 14'h0000, 8'h00);
		20: v = mem_row(1'b1, 1'b0, 1'b0, 1'b1, 21'h000000, 8'hcc, 14'h0000, 8'h00);
		// Read back XRAM and VRAM.
		21: v = mem_row(1'b0, 1'b0, 1'b1, 1'b0, 21'h000000, 8'h00, 14'h0000, 8'h00);
		22: v = mem_row(1'b0, 1'b0, 1'b1, 1'b1, 21'h000002, 8'h40, 14'h0001, 8'h55);
		23: v = mem_row(1'b0, 1'b0, 1'b1, 1'b1, 21'h000400, 8'h41, 14'h0040, 8'haa);
		24: v = mem_row(1'b0, 1'b0, 1'b1, 1'b1, 21'h010000, 8'h42, 14'h2000, 8'h0f);
		25: v = mem_row(1'b0, 1'b0, 1'b0, 1'b1, 21'h000000, 8'h43, 14'h0000, 8'hf0);
		default: v = '0;
	endcase
	return v;
endfunction

`endif

// File: board_bus_pkg.sv
package board_bus_pkg;

	localparam int mem_addr_w   = 21;
	localparam int vid_addr_w   = 14;
	localparam int data_w       = 8;
	localparam int lcd_w        = 8;
	localparam int pxx_w        = 6;
	localparam int strobe_phase = 4;

	// ########################################
	// Cartridge side buses, controls active high.
	// ########################################

	typedef struct packed {
		logic [mem_addr_w-1:0] addr;
		logic [data_w-1:0]     data;
		logic                  oe;
		logic                  rd;
		logic                  wr;
		logic                  prog;
		logic                  cs_rom;
		logic                  cs_xram;
	} mem_bus_t;

	typedef struct packed {
		logic [vid_addr_w-1:0] addr;
		logic [data_w-1:0]     data;
		logic                  oe;
		logic                  rd;
		logic                  wr;
		logic                  cs;
	} vid_bus_t;

	// LCD pins, MSB first.
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       latch;
		logic       altsig;
		logic       ctrl;
		logic       clk;
		logic [1:0] data;
	} lcd_pins_t;

	// One sequencer step.
	typedef struct packed {
		mem_bus_t         mem;
		vid_bus_t         vid;
		lcd_pins_t        lcd;
		logic             pxx_test;
		logic             lcd_test;
		logic             md_test;
		logic             vd_test;
		logic [lcd_w-1:0] exp_adr;
	} test_vector_t;

endpackage

// File: test_status_pkg.sv
package test_status_pkg;

	localparam int lane_count = 4;

	localparam int lane_pxx = 0;
	localparam int lane_lcd = 1;
	localparam int lane_md  = 2;
	localparam int lane_vd  = 3;

	// ########################################
	// Check lane input.
	// ########################################

	typedef struct packed {
		logic                             test;
		logic [board_bus_pkg::data_w-1:0] expected;
		logic [board_bus_pkg::data_w-1:0] actual;
	} lane_check_t;

	// Values outside the list show a blank display.
	typedef enum logic [7:0] {
		mode_status   = 8'd0,
		mode_switches = 8'd1,
		mode_loopback = 8'd2
	} led_mode_t;

endpackage

// File: vector_sequencer.sv
`timescale 1ns/1ps

module vector_sequencer #(
	parameter int step_log2    = 4,
	parameter int step_index_w = 6
) (
	input  logic                                                  clk12m,
	input  logic                                                  rst_n,
	output board_bus_pkg::mem_bus_t                               mem,
	output board_bus_pkg::vid_bus_t                               vid,
	output board_bus_pkg::lcd_pins_t                              lcd,
	input  logic [board_bus_pkg::pxx_w-1:0]                       pxx_in,
	input  logic [board_bus_pkg::lcd_w-1:0]                       adr_in,
	input  logic [board_bus_pkg::data_w-1:0]                      mdata_in,
	input  logic [board_bus_pkg::data_w-1:0]                      vdata_in,
	output test_status_pkg::lane_check_t [test_status_pkg::lane_count-1:0] checks,
	output logic                                                  strobe,
	output logic                                                  round_end
);

	`include "vector_table.svh"

	localparam int cyc_w = step_log2 + step_index_w;

	logic [cyc_w-1:0]            cyc;
	logic [step_index_w-1:0]     step;
	logic [step_log2-1:0]        phase;
	board_bus_pkg::test_vector_t row;

	// ########################################
	// Step timing.
	// ########################################

	always_ff @(posedge clk12m) begin
		if (!rst_n) begin
			cyc <= '0;
		end else begin
			cyc <= cyc + 1'b1;
		end
	end

	assign step      = cyc[cyc_w-1:step_log2];
	assign phase     = cyc[step_log2-1:0];
	assign strobe    = phase == step_log2'(board_bus_pkg::strobe_phase);
	assign round_end = strobe && (&step);

	// Table read, settled well before the strobe.
	always_ff @(posedge clk12m) begin
		row <= vector_row(step);
	end

	always_ff @(posedge clk12m) begin
		if (!rst_n) begin
			mem <= '0;
			vid <= '0;
			lcd <= '0;
		end else if (strobe) begin
			mem <= row.mem;
			vid <= row.vid;
			lcd <= row.lcd;
		end
	end

	// ########################################
	// Lane feed.
	// ########################################

	always_comb begin
		checks[test_status_pkg::lane_pxx].test     = row.pxx_test;
		checks[test_status_pkg::lane_pxx].expected =
			{{(board_bus_pkg::data_w - board_bus_pkg::pxx_w){1'b0}},
			 row.mem.addr[board_bus_pkg::pxx_w-1:0]};
		checks[test_status_pkg::lane_pxx].actual   =
			{{(board_bus_pkg::data_w - board_bus_pkg::pxx_w){1'b0}}, pxx_in};
		checks[test_status_pkg::lane_lcd].test     = row.lcd_test;
		checks[test_status_pkg::lane_lcd].expected = row.exp_adr;
		checks[test_status_pkg::lane_lcd].actual   = adr_in;
		checks[test_status_pkg::lane_md].test      = row.md_test;
		checks[test_status_pkg::lane_md].expected  = row.mem.data;
		checks[test_status_pkg::lane_md].actual    = mdata_in;
		checks[test_status_pkg::lane_vd].test      = row.vd_test;
		checks[test_status_pkg::lane_vd].expected  = row.vid.data;
		checks[test_status_pkg::lane_vd].actual    = vdata_in;
	end

endmodule

// File: check_lane.sv
`timescale 1ns/1ps

module check_lane #(
	parameter int lane_w = 8
) (
	input  logic                         clk12m,
	input  logic                         rst_n,
	input  logic                         strobe,
	input  logic                         round_end,
	input  test_status_pkg::lane_check_t check,
	output logic [lane_w-1:0]            result
);

	logic [lane_w-1:0] mask;
	logic [lane_w-1:0] mask_next;

	// A bit stays good only while every tested step matches.
	always_comb begin
		mask_next = mask;
		if (strobe && check.test) begin
			mask_next = mask & ~(check.expected[lane_w-1:0] ^ check.actual[lane_w-1:0]);
		end
	end

	always_ff @(posedge clk12m) begin
		if (!rst_n) begin
			mask   <= '1;
			result <= '0;
		end else if (round_end) begin
			result <= mask_next;
			mask   <= '1;
		end else begin
			mask <= mask_next;
		end
	end

endmodule

// File: status_display.sv
`timescale 1ns/1ps

module status_display #(
	parameter int lane_w = 8
) (
	input  logic                                             clk12m,
	input  logic                                             rst_n,
	input  logic [15:0]                                      sw,
	input  logic [3:0]                                       btn,
	input  logic [test_status_pkg::lane_count-1:0][lane_w-1:0] results,
	output logic [15:0]                                      led
);

	test_status_pkg::led_mode_t led_mode;

	always_ff @(posedge clk12m) begin
		if (!rst_n) begin
			led_mode <= test_status_pkg::mode_status;
		end else if (btn[0]) begin
			led_mode <= test_status_pkg::led_mode_t'(sw[7:0]);
		end
	end

	// ########################################
	// LED selection.
	// ########################################

	always_comb begin
		led = '0;
		case (led_mode)
			test_status_pkg::mode_status: begin
				led[12] = btn[1];
				led[11] = btn[2];
				led[10] = btn[3];
				led[3]  = &results[test_status_pkg::lane_vd];
				led[2]  = &results[test_status_pkg::lane_md];
				led[1]  = &results[test_status_pkg::lane_lcd][board_bus_pkg::lcd_w-1:0];
				led[0]  = &results[test_status_pkg::lane_pxx][board_bus_pkg::pxx_w-1:0];
			end
			test_status_pkg::mode_switches: begin
				led = sw;
			end
			test_status_pkg::mode_loopback: begin
				led[15:8] = results[test_status_pkg::lane_lcd][board_bus_pkg::lcd_w-1:0];
				led[5:0]  = results[test_status_pkg::lane_pxx][board_bus_pkg::pxx_w-1:0];
			end
			default: begin
				led = '0;
			end
		endcase
	end

endmodule

// File: board_test_top.sv
`timescale 1ns/1ps

module board_test_top #(
	parameter int step_log2    = 4,
	parameter int step_index_w = 6,
	parameter int lane_w       = 8
) (
	input  logic                                 clk12m,
	input  logic                                 rst_n,
	input  logic [15:0]                          sw,
	input  logic [3:0]                           btn,
	output logic [15:0]                          led,
	output logic [board_bus_pkg::mem_addr_w-1:0] madr,
	output logic [board_bus_pkg::data_w-1:0]     mdata_out,
	output logic                                 mdata_oe,
	input  logic [board_bus_pkg::data_w-1:0]     mdata_in,
	output logic                                 n_mrd,
	output logic                                 n_mwr,
	output logic                                 n_prog,
	output logic                                 n_mcs_crom,
	output logic                                 n_mcs_cram,
	output logic [board_bus_pkg::vid_addr_w-1:0] vadr,
	output logic [board_bus_pkg::data_w-1:0]     vdata_out,
	output logic                                 vdata_oe,
	input  logic [board_bus_pkg::data_w-1:0]     vdata_in,
	output logic                                 n_vrd,
	output logic                                 n_vwr,
	output logic                                 n_vcs,
	output board_bus_pkg::lcd_pins_t             lcd,
	input  logic [board_bus_pkg::pxx_w-1:0]      pxx_in,
	input  logic [board_bus_pkg::lcd_w-1:0]      adr_in
);

	board_bus_pkg::mem_bus_t                                        mem;
	board_bus_pkg::vid_bus_t                                        vid;
	test_status_pkg::lane_check_t [test_status_pkg::lane_count-1:0] checks;
	logic                                                           strobe;
	logic                                                           round_end;
	logic [test_status_pkg::lane_count-1:0][lane_w-1:0]             results;

	vector_sequencer #(
		.step_log2    (step_log2),
		.step_index_w (step_index_w)
	) i_vector_sequencer (
		.clk12m    (clk12m),
		.rst_n     (rst_n),
		.mem       (mem),
		.vid       (vid),
		.lcd       (lcd),
		.pxx_in    (pxx_in),
		.adr_in    (adr_in),
		.mdata_in  (mdata_in),
		.vdata_in  (vdata_in),
		.checks    (checks),
		.strobe    (strobe),
		.round_end (round_end)
	);

	for (genvar i = 0; i < test_status_pkg::lane_count; i++) begin : g_lane
		check_lane #(
			.lane_w (lane_w)
		) i_check_lane (
			.clk12m    (clk12m),
			.rst_n     (rst_n),
			.strobe    (strobe),
			.round_end (round_end),
			.check     (checks[i]),
			.result    (results[i])
		);
	end

	status_display #(
		.lane_w (lane_w)
	) i_status_display (
		.clk12m  (clk12m),
		.rst_n   (rst_n),
		.sw      (sw),
		.btn     (btn),
		.results (results),
		.led     (led)
	);

	// Board pins, strobes and selects active low.
	assign madr       = mem.addr;
	assign mdata_out  = mem.data;
	assign mdata_oe   = mem.oe;
	assign n_mrd      = !mem.rd;
	assign n_mwr      = !mem.wr;
	assign n_prog     = !mem.prog;
	assign n_mcs_crom = !mem.cs_rom;
	assign n_mcs_cram = !mem.cs_xram;
	assign vadr       = vid.addr;
	assign vdata_out  = vid.data;
	assign vdata_oe   = vid.oe;
	assign n_vrd      = !vid.rd;
	assign n_vwr      = !vid.wr;
	assign n_vcs      = !vid.cs;

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int half_period  = 10,
	parameter int reset_cycles = 4
) (
	output logic clk12m,
	output logic rst_n
);

	initial begin
		clk12m = 1'b0;
		forever #half_period clk12m = ~clk12m;
	end

	// Reset spans reset_cycles rising edges and is released on a falling edge.
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(negedge clk12m);
		rst_n = 1'b1;
	end

endmodule

// File: board_test_tb.sv
`timescale 1ns/1ps

module board_test_tb;

	localparam int step_log2      = 4;
	localparam int step_index_w   = 6;
	localparam int round_cycles   = 1 << (step_log2 + step_index_w);
	localparam int n_rows         = 11;
	localparam int timeout_cycles = n_rows * (round_cycles + 8) + 20;

	typedef enum logic [2:0] {
		fault_none,
		fault_p12,
		fault_adr5,
		fault_vram,
		fault_xram
	} fault_t;

	typedef struct packed {
		fault_t      fault;
		logic [15:0] sw;
		logic [3:0]  btn;
		logic [15:0] led;
	} test_row_t;

	logic                                 clk12m;
	logic                                 rst_n;
	logic [15:0]                          sw;
	logic [3:0]                           btn;
	logic [15:0]                          led;
	logic [board_bus_pkg::mem_addr_w-1:0] madr;
	logic [board_bus_pkg::data_w-1:0]     mdata_out;
	logic                                 mdata_oe;
	logic [board_bus_pkg::data_w-1:0]     mdata_in;
	logic                                 n_mrd;
	logic                                 n_mwr;
	logic                                 n_prog;
	logic                                 n_mcs_crom;
	logic                                 n_mcs_cram;
	logic [board_bus_pkg::vid_addr_w-1:0] vadr;
	logic [board_bus_pkg::data_w-1:0]     vdata_out;
	logic                                 vdata_oe;
	logic [board_bus_pkg::data_w-1:0]     vdata_in;
	logic                                 n_vrd;
	logic                                 n_vwr;
	logic                                 n_vcs;
	board_bus_pkg::lcd_pins_t             lcd;
	logic [board_bus_pkg::pxx_w-1:0]      pxx_in;
	logic [board_bus_pkg::lcd_w-1:0]      adr_in;

	fault_t    fault;
	int        error_count;
	test_row_t rows [n_rows];
	string     row_names [n_rows];

	logic [7:0] rom_mem [0:(1 << 21) - 1];
	logic [7:0] xram_mem [0:(1 << 17) - 1];
	logic [7:0] vram_mem [0:(1 << 14) - 1];

	tb_clock_gen i_tb_clock_gen (
		.clk12m (clk12m),
		.rst_n  (rst_n)
	);

	board_test_top i_board_test_top (
		.clk12m     (clk12m),
		.rst_n      (rst_n),
		.sw         (sw),
		.btn        (btn),
		.led        (led),
		.madr       (madr),
		.mdata_out  (mdata_out),
		.mdata_oe   (mdata_oe),
		.mdata_in   (mdata_in),
		.n_mrd      (n_mrd),
		.n_mwr      (n_mwr),
		.n_prog     (n_prog),
		.n_mcs_crom (n_mcs_crom),
		.n_mcs_cram (n_mcs_cram),
		.vadr       (vadr),
		.vdata_out  (vdata_out),
		.vdata_oe   (vdata_oe),
		.vdata_in   (vdata_in),
		.n_vrd      (n_vrd),
		.n_vwr      (n_vwr),
		.n_vcs      (n_vcs),
		.lcd        (lcd),
		.pxx_in     (pxx_in),
		.adr_in     (adr_in)
	);

	// ########################################
	// Board jumpers and memory chips.
	// ########################################

	assign pxx_in = {madr[5:3], madr[2] & (fault != fault_p12), madr[1:0]};
	assign adr_in = {lcd.latch, lcd.ctrl, lcd.data[0] & (fault != fault_adr5),
		lcd.hsync, lcd.clk, lcd.data[1], lcd.vsync, lcd.altsig};

	// Undriven buses float high.
	assign mdata_in = mdata_oe ? mdata_out :
		(!n_mrd && !n_mcs_crom) ? rom_mem[madr] :
		(!n_mrd && !n_mcs_cram) ? xram_mem[madr[16:0]] ^ {7'b0, fault == fault_xram} :
		8'hff;
	assign vdata_in = vdata_oe ? vdata_out :
		(!n_vrd && !n_vcs) ? vram_mem[vadr] ^ {7'b0, fault == fault_vram} :
		8'hff;

	always @(posedge clk12m) begin
		if (!n_prog && !n_mcs_crom) begin
			rom_mem[madr] <= mdata_in;
		end
		if (!n_mwr && !n_mcs_cram) begin
			xram_mem[madr[16:0]] <= mdata_in;
		end
		if (!n_vwr && !n_vcs) begin
			vram_mem[vadr] <= vdata_in;
		end
	end

	// ########################################
	// Checks and the row table.
	// ########################################

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected) else begin
			error_count++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic set_row(input int idx, input string name, input fault_t kind,
		input logic [15:0] sw_val, input logic [3:0] btn_val, input logic [15:0] led_val);
		rows[idx]      = '{kind, sw_val, btn_val, led_val};
		row_names[idx] = name;
	endtask

	// Each row covers one whole round; btn[0] loads sw[7:0] as the LED mode.
	task automatic build_table();
		set_row(0, "clean_buttons", fault_none, 16'h0000, 4'b1110, 16'h1c0f);
		set_row(1, "p12_cut_loopback", fault_p12, 16'h0002, 4'b0001, 16'hff3b);
		set_row(2, "p12_cut_status", fault_p12, 16'h0000, 4'b0011, 16'h100e);
		set_row(3, "adr5_cut_loopback", fault_adr5, 16'h0002, 4'b0001, 16'hdf3f);
		set_row(4, "adr5_cut_status", fault_adr5, 16'h0000, 4'b1001, 16'h040d);
		set_row(5, "vram_bit0_flip", fault_vram, 16'h0000, 4'b0000, 16'h0007);
		set_row(6, "xram_bit0_flip", fault_xram, 16'h0000, 4'b0000, 16'h000b);
		set_row(7, "recovered", fault_none, 16'h0000, 4'b0000, 16'h000f);
		set_row(8, "switch_mode", fault_none, 16'ha501, 4'b0001, 16'ha501);
		set_row(9, "blank_mode", fault_none, 16'h0007, 4'b0001, 16'h0000);
		set_row(10, "status_restore", fault_none, 16'h0000, 4'b0001, 16'h000f);
	endtask

	task automatic check_reset_state();
		check_value("reset n_mrd", 16'h1, {15'b0, n_mrd});
		check_value("reset n_mwr", 16'h1, {15'b0, n_mwr});
		check_value("reset n_prog", 16'h1, {15'b0, n_prog});
		check_value("reset n_mcs_crom", 16'h1, {15'b0, n_mcs_crom});
		check_value("reset n_mcs_cram", 16'h1, {15'b0, n_mcs_cram});
		check_value("reset n_vrd", 16'h1, {15'b0, n_vrd});
		check_value("reset n_vwr", 16'h1, {15'b0, n_vwr});
		check_value("reset n_vcs", 16'h1, {15'b0, n_vcs});
		check_value("reset mdata_oe", 16'h0, {15'b0, mdata_oe});
		check_value("reset vdata_oe", 16'h0, {15'b0, vdata_oe});
		check_value("reset lcd", 16'h0, {8'b0, lcd});
		check_value("reset led", 16'h0, led);
	endtask

	initial begin
		sw          = '0;
		btn         = '0;
		fault       = fault_none;
		error_count = 0;
		build_table();
		@(posedge rst_n);
		check_reset_state();
		// Rows start inside the first 20 cycles of a round, ahead of its first tested strobe.
		for (int i = 0; i < n_rows; i++) begin
			sw    = rows[i].sw;
			btn   = rows[i].btn;
			fault = rows[i].fault;
			repeat (round_cycles + 2) @(negedge clk12m);
			check_value(row_names[i], rows[i].led, led);
		end
		$display("Errors: %0d", error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk12m);
		$display("Timed out after %0d cycles before all rows were checked", timeout_cycles);
		$display("Errors: %0d", error_count);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: board_test_top.f
+incdir+.
board_bus_pkg.sv
test_status_pkg.sv
vector_sequencer.sv
check_lane.sv
status_display.sv
board_test_top.sv
tb_clock_gen.sv
board_test_tb.sv

// File: Bender.yml
package:
  name: board_test

sources:
  - include_dirs:
      - .
    files:
      - board_bus_pkg.sv
      - test_status_pkg.sv
      - vector_sequencer.sv
      - check_lane.sv
      - status_display.sv
      - board_test_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - board_test_tb.sv
